/* hdl/decodePkg.sv */
// Shared types and encodings for the MIPS-style decode stage
// Imported by every design unit that needs a width, opcode or enum

`default_nettype none

package decodePkg;

	typedef logic [31:0] word_t;    // Data or address word
	typedef logic [4:0]  regAddr_t; // Register index
	typedef logic [4:0]  shamt_t;
	typedef logic [31:0] instr_t;

	localparam int       NUM_REGS    = 32;
	localparam regAddr_t LINK_REG    = 5'd31; // Written by jal
	localparam word_t    LINK_OFFSET = 32'd4;

	//////////////////////////////////////////////////
	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	//////////////////////////////////////////////////
	// Function field under OP_SPECIAL
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// Add first so a cleared register reads as add
	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_LUI
	} aluOp_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ
	} branchCond_t;

endpackage

`default_nettype wire

/* hdl/decodeIf.sv */
// Decoded control word, driven by the instruction decoder
// and read by the stage register and the branch unit

`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
	import decodePkg::*;

	aluOp_t      aluOp;
	logic        regWrite;
	logic        memRead;
	logic        memWrite;
	logic        memToReg;   // Load result goes to the register file
	logic        aluSrc;     // B from immediate
	logic        link;
	logic        jump;
	logic        jumpReg;
	branchCond_t branchCond;
	regAddr_t    writeReg;
	word_t       imm;        // Extended immediate

	modport decoder (output aluOp, regWrite, memRead, memWrite, memToReg, aluSrc,
		link, jump, jumpReg, branchCond, writeReg, imm);
	modport sink (input aluOp, regWrite, memRead, memWrite, memToReg, aluSrc,
		link, jump, jumpReg, branchCond, writeReg, imm);
endinterface

`default_nettype wire

/* hdl/instrDecoder.sv */
// Combinational decoder from instruction word to control word
// Also produces the extended immediate and the destination register

`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input wire decodePkg::instr_t instr,
	decodeIf.decoder              ctrl
);
	import decodePkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t   rt;
	regAddr_t   rd;
	logic       immOp;    // Immediate ALU form
	logic       zeroExt;
	logic       upperImm; // lui

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// Register format writes rd, jal writes the link register
	assign ctrl.writeReg = (opcode == OP_SPECIAL) ? rd :
		((opcode == OP_JAL) ? LINK_REG : rt);

	//////////////////////////////////////////////////
	// Control decode
	always_comb begin
		ctrl.aluOp      = ALU_ADD;
		ctrl.regWrite   = 1'b0;
		ctrl.memRead    = 1'b0;
		ctrl.memWrite   = 1'b0;
		ctrl.memToReg   = 1'b0;
		ctrl.aluSrc     = 1'b0;
		ctrl.link       = 1'b0;
		ctrl.jump       = 1'b0;
		ctrl.jumpReg    = 1'b0;
		ctrl.branchCond = BR_NONE;
		immOp           = 1'b0;
		zeroExt         = 1'b0;
		upperImm        = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					FN_SLL:  ctrl.aluOp = ALU_SLL;
					FN_SRL:  ctrl.aluOp = ALU_SRL;
					FN_SRA:  ctrl.aluOp = ALU_SRA;
					FN_ADD:  ctrl.aluOp = ALU_ADD;
					FN_ADDU: ctrl.aluOp = ALU_ADDU;
					FN_SUB:  ctrl.aluOp = ALU_SUB;
					FN_SUBU: ctrl.aluOp = ALU_SUBU;
					FN_AND:  ctrl.aluOp = ALU_AND;
					FN_OR:   ctrl.aluOp = ALU_OR;
					FN_XOR:  ctrl.aluOp = ALU_XOR;
					FN_NOR:  ctrl.aluOp = ALU_NOR;
					FN_SLT:  ctrl.aluOp = ALU_SLT;
					FN_SLTU: ctrl.aluOp = ALU_SLTU;
					FN_JR: begin
						ctrl.regWrite = 1'b0;
						ctrl.jump     = 1'b1;
						ctrl.jumpReg  = 1'b1;
					end
					default: ctrl.regWrite = 1'b0; // Unknown function is a no-op
				endcase
			end
			OP_J:    ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump     = 1'b1;
				ctrl.link     = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_BEQ:  ctrl.branchCond = BR_EQ;
			OP_BNE:  ctrl.branchCond = BR_NE;
			OP_BLEZ: ctrl.branchCond = BR_LEZ;
			OP_BGTZ: ctrl.branchCond = BR_GTZ;
			OP_ADDI:  immOp = 1'b1;
			OP_ADDIU: begin
				immOp      = 1'b1;
				ctrl.aluOp = ALU_ADDU;
			end
			OP_SLTI: begin
				immOp      = 1'b1;
				ctrl.aluOp = ALU_SLT;
			end
			OP_ANDI: begin
				immOp      = 1'b1;
				zeroExt    = 1'b1;
				ctrl.aluOp = ALU_AND;
			end
			OP_ORI: begin
				immOp      = 1'b1;
				zeroExt    = 1'b1;
				ctrl.aluOp = ALU_OR;
			end
			OP_XORI: begin
				immOp      = 1'b1;
				zeroExt    = 1'b1;
				ctrl.aluOp = ALU_XOR;
			end
			OP_LUI: begin
				immOp      = 1'b1;
				upperImm   = 1'b1;
				ctrl.aluOp = ALU_LUI;
			end
			OP_LW: begin
				immOp         = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			OP_SW: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			default: ; // Unknown opcode decodes as a no-op
		endcase
		if (immOp) begin
			ctrl.aluSrc   = 1'b1;
			ctrl.regWrite = 1'b1;
		end
	end

	// Immediate extension
	always_comb begin
		if (upperImm)
			ctrl.imm = {instr[15:0], 16'h0000};
		else if (zeroExt)
			ctrl.imm = {16'h0000, instr[15:0]};
		else
			ctrl.imm = {{16{instr[15]}}, instr[15:0]};
	end
endmodule

`default_nettype wire

/* hdl/operandFetch.sv */
// 32-entry register file with execute, memory and writeback forwarding
// Both source operands are resolved in the decode cycle

`timescale 1ns/1ps
`default_nettype none

module operandFetch (
	input wire logic                 CLK,
	input wire decodePkg::instr_t    instr,
	input wire logic                 exWriteEn,
	input wire decodePkg::regAddr_t  exWriteReg,
	input wire decodePkg::word_t     exResult,
	input wire logic                 memWriteEn,
	input wire decodePkg::regAddr_t  memWriteReg,
	input wire decodePkg::word_t     memData,
	input wire logic                 wbWriteEn,
	input wire decodePkg::regAddr_t  wbWriteReg,
	input wire decodePkg::word_t     wbData,
	output decodePkg::word_t         opA,
	output decodePkg::word_t         rtValue
);
	import decodePkg::*;

	word_t regFile [NUM_REGS];

	// Youngest producer wins
	function automatic word_t forward(regAddr_t src, word_t fileValue);
		word_t value;
		if (exWriteEn && (exWriteReg == src))
			value = exResult;
		else if (memWriteEn && (memWriteReg == src))
			value = memData;
		else if (wbWriteEn && (wbWriteReg == src))
			value = wbData;
		else
			value = fileValue;
		return value;
	endfunction

	always_ff @(posedge CLK) begin
		if (wbWriteEn)
			regFile[wbWriteReg] <= wbData;
	end

	always_comb begin
		opA     = forward(instr[25:21], regFile[instr[25:21]]); // rs
		rtValue = forward(instr[20:16], regFile[instr[20:16]]); // rt
	end
endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
// Same-cycle branch resolution and next fetch address
// Jumps always redirect, branches only when the condition holds

`timescale 1ns/1ps
`default_nettype none

module branchUnit (
	input wire decodePkg::word_t  opA,
	input wire decodePkg::word_t  opB,
	input wire decodePkg::word_t  pca,
	input wire decodePkg::word_t  cia,
	input wire decodePkg::instr_t instr,
	decodeIf.sink                 ctrl,
	output logic                  takenBranch,
	output decodePkg::word_t      nextPc
);
	import decodePkg::*;

	logic condMet;

	always_comb begin
		case (ctrl.branchCond)
			BR_EQ:   condMet = (opA == opB);
			BR_NE:   condMet = (opA != opB);
			BR_LEZ:  condMet = ($signed(opA) <= 0);
			BR_GTZ:  condMet = ($signed(opA) > 0);
			default: condMet = 1'b0;
		endcase
	end

	assign takenBranch = condMet | ctrl.jump;

	always_comb begin
		if (ctrl.jumpReg)
			nextPc = opA;                                // jr
		else if (ctrl.jump)
			nextPc = {cia[31:28], instr[25:0], 2'b00};   // Region jump
		else if (condMet)
			nextPc = pca + {ctrl.imm[29:0], 2'b00};
		else
			nextPc = pca;
	end
endmodule

`default_nettype wire

/* hdl/idexRegister.sv */
// Decode/execute stage register
// Picks the ALU operands, applies the register-0 writeback rule, holds on freeze

`timescale 1ns/1ps
`default_nettype none

module idexRegister (
	input wire logic              CLK,
	input wire logic              RESET,
	input wire logic              freeze,
	input wire decodePkg::word_t  opA,
	input wire decodePkg::word_t  rtValue,
	input wire decodePkg::word_t  pca,
	input wire decodePkg::instr_t instr,
	decodeIf.sink                 ctrl,
	output decodePkg::word_t      aOut,
	output decodePkg::word_t      bOut,
	output decodePkg::word_t      storeData,
	output decodePkg::regAddr_t   writeReg,
	output logic                  writeBack,
	output logic                  memRead,
	output logic                  memWrite,
	output logic                  memToReg,
	output decodePkg::aluOp_t     aluOp,
	output decodePkg::shamt_t     shamt
);
	import decodePkg::*;

	word_t aNext;
	word_t bNext;
	logic  writeBackNext;

	// Link computes pca + 4 in execute
	always_comb begin
		if (ctrl.link) begin
			aNext = pca;
			bNext = LINK_OFFSET;
		end else begin
			aNext = opA;
			bNext = ctrl.aluSrc ? ctrl.imm : rtValue;
		end
	end

	// No writeback to register 0, loads always write back
	assign writeBackNext = (ctrl.regWrite && (ctrl.writeReg != '0)) || ctrl.memToReg;

	//////////////////////////////////////////////////
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			aOut      <= '0;
			bOut      <= '0;
			storeData <= '0;
			writeReg  <= '0;
			writeBack <= 1'b0;
			memRead   <= 1'b0;
			memWrite  <= 1'b0;
			memToReg  <= 1'b0;
			aluOp     <= ALU_ADD;
			shamt     <= '0;
		end else if (!freeze) begin
			aOut      <= aNext;
			bOut      <= bNext;
			storeData <= rtValue;
			writeReg  <= ctrl.writeReg;
			writeBack <= writeBackNext;
			memRead   <= ctrl.memRead;
			memWrite  <= ctrl.memWrite;
			memToReg  <= ctrl.memToReg;
			aluOp     <= ctrl.aluOp;
			shamt     <= instr[10:6];
		end
	end
endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
// Instruction decode stage top level
// Decoder and operand fetch feed the branch unit and the decode/execute register

`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input wire logic                CLK,
	input wire logic                RESET,
	input wire logic                freeze,
	input wire decodePkg::instr_t   instr,
	input wire decodePkg::word_t    pca,         // Address after this instruction
	input wire decodePkg::word_t    cia,         // Address of this instruction
	input wire decodePkg::word_t    exResult,
	input wire logic                memWriteEn,
	input wire decodePkg::regAddr_t memWriteReg,
	input wire decodePkg::word_t    memData,
	input wire logic                wbWriteEn,
	input wire decodePkg::regAddr_t wbWriteReg,
	input wire decodePkg::word_t    wbData,
	output logic                    takenBranch,
	output decodePkg::word_t        nextPc,
	output decodePkg::word_t        aOut,
	output decodePkg::word_t        bOut,
	output decodePkg::word_t        storeData,
	output decodePkg::regAddr_t     writeReg,
	output logic                    writeBack,
	output logic                    memRead,
	output logic                    memWrite,
	output logic                    memToReg,
	output decodePkg::aluOp_t       aluOp,
	output decodePkg::shamt_t       shamt
);
	import decodePkg::*;

	word_t opA;
	word_t rtValue;

	decodeIf ctrl ();

	instrDecoder decoder (
		.instr (instr),
		.ctrl  (ctrl.decoder)
	);

	//////////////////////////////////////////////////
	// Execute forwarding comes straight from the stage register
	operandFetch fetch (
		.CLK         (CLK),
		.instr       (instr),
		.exWriteEn   (writeBack),
		.exWriteReg  (writeReg),
		.exResult    (exResult),
		.memWriteEn  (memWriteEn),
		.memWriteReg (memWriteReg),
		.memData     (memData),
		.wbWriteEn   (wbWriteEn),
		.wbWriteReg  (wbWriteReg),
		.wbData      (wbData),
		.opA         (opA),
		.rtValue     (rtValue)
	);

	branchUnit branch (
		.opA         (opA),
		.opB         (rtValue),
		.pca         (pca),
		.cia         (cia),
		.instr       (instr),
		.ctrl        (ctrl.sink),
		.takenBranch (takenBranch),
		.nextPc      (nextPc)
	);

	idexRegister idex (
		.CLK       (CLK),
		.RESET     (RESET),
		.freeze    (freeze),
		.opA       (opA),
		.rtValue   (rtValue),
		.pca       (pca),
		.instr     (instr),
		.ctrl      (ctrl.sink),
		.aOut      (aOut),
		.bOut      (bOut),
		.storeData (storeData),
		.writeReg  (writeReg),
		.writeBack (writeBack),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.memToReg  (memToReg),
		.aluOp     (aluOp),
		.shamt     (shamt)
	);
endmodule

`default_nettype wire

/* dv/decodeStageTb.sv */
// Self-checking testbench for the decode stage
// Drives random and directed instructions and compares against a reference model

`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;
	import decodePkg::*;

	typedef struct packed {
		word_t    aOut;
		word_t    bOut;
		word_t    storeData;
		regAddr_t writeReg;
		logic     writeBack;
		logic     memRead;
		logic     memWrite;
		logic     memToReg;
		aluOp_t   aluOp;
		shamt_t   shamt;
	} stage_t;

	typedef struct packed {
		logic   taken;
		word_t  nextPc;
		stage_t stage;
	} result_t;

	// Reset, preload, ALU, immediates, forwarding, branches, jumps, freeze, reset, tail
	localparam int STIM_CYCLES    = 4 + 32 + 13 + 22 + 16 + 30 + 4 + 6 + 5 + 2;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

	localparam logic [5:0] ALU_FNS [13] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADD, FN_ADDU,
		FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
	localparam logic [5:0] IMM_OPS [9] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI,
		OP_XORI, OP_LUI, OP_LW, OP_SW};
	localparam logic [5:0] BR_OPS [4] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};

	logic     CLK = 1'b0;
	logic     RESET;
	logic     freeze;
	instr_t   instr;
	word_t    pca;
	word_t    cia;
	word_t    exResult;
	logic     memWriteEn;
	regAddr_t memWriteReg;
	word_t    memData;
	logic     wbWriteEn;
	regAddr_t wbWriteReg;
	word_t    wbData;
	logic     takenBranch;
	word_t    nextPc;
	word_t    aOut;
	word_t    bOut;
	word_t    storeData;
	regAddr_t writeReg;
	logic     writeBack;
	logic     memRead;
	logic     memWrite;
	logic     memToReg;
	aluOp_t   aluOp;
	shamt_t   shamt;

	integer  seed = 32'h3a920b8a;
	int      cycleCount = 0;
	word_t   modelRegs [32];  // Model register file
	stage_t  expReg = '0;     // Expected stage register contents
	result_t res;

	decodeStage dut (.*);

	always #4 CLK = ~CLK;

	//////////////////////////////////////////////////
	// Stimulus helpers
	function automatic word_t randWord();
		word_t value;
		value = $random(seed);
		return value;
	endfunction

	function automatic regAddr_t randReg();
		word_t value;
		value = $random(seed);
		return value[4:0];
	endfunction

	function automatic logic [15:0] randImm(input logic negative);
		word_t value;
		value = $random(seed);
		value[15] = negative;
		return value[15:0];
	endfunction

	function automatic instr_t rType(input regAddr_t rs, input regAddr_t rt,
		input regAddr_t rd, input shamt_t sh, input logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic instr_t iType(input logic [5:0] op, input regAddr_t rs,
		input regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instr_t jType(input logic [5:0] op, input word_t target);
		return {op, target[25:0]};
	endfunction

	// One instruction per rising edge with a random fetch address
	task automatic issue(input instr_t ins, input logic memEn = 1'b0,
		input regAddr_t memReg = '0, input logic wbEn = 1'b0, input regAddr_t wbReg = '0,
		input word_t wbValue = '0, input logic frz = 1'b0);
		word_t addr;
		@(posedge CLK);
		addr = randWord();
		addr[1:0] = 2'b00;
		instr       <= ins;
		cia         <= addr;
		pca         <= addr + 32'd4;
		freeze      <= frz;
		exResult    <= randWord();
		memWriteEn  <= memEn;
		memWriteReg <= memReg;
		memData     <= randWord();
		wbWriteEn   <= wbEn;
		wbWriteReg  <= wbReg;
		wbData      <= wbValue;
	endtask

	//////////////////////////////////////////////////
	// Reference model
	function automatic word_t forwardedValue(input regAddr_t src);
		if (expReg.writeBack && (expReg.writeReg == src))
			return exResult;
		if (memWriteEn && (memWriteReg == src))
			return memData;
		if (wbWriteEn && (wbWriteReg == src))
			return wbData;
		return modelRegs[src];
	endfunction

	function automatic result_t refDecode();
		result_t    r;
		logic [5:0] op;
		logic [5:0] fn;
		word_t      a;
		word_t      b;
		word_t      immS;
		word_t      imm;
		aluOp_t     aluSel;
		logic       aluFn;
		logic       useImm;
		logic       regWr;
		logic       jr;
		logic       isJump;
		logic       cond;
		op   = instr[31:26];
		fn   = instr[5:0];
		a    = forwardedValue(instr[25:21]);
		b    = forwardedValue(instr[20:16]);
		immS = {{16{instr[15]}}, instr[15:0]};
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_SLL:  aluSel = ALU_SLL;
					FN_SRL:  aluSel = ALU_SRL;
					FN_SRA:  aluSel = ALU_SRA;
					FN_ADDU: aluSel = ALU_ADDU;
					FN_SUB:  aluSel = ALU_SUB;
					FN_SUBU: aluSel = ALU_SUBU;
					FN_AND:  aluSel = ALU_AND;
					FN_OR:   aluSel = ALU_OR;
					FN_XOR:  aluSel = ALU_XOR;
					FN_NOR:  aluSel = ALU_NOR;
					FN_SLT:  aluSel = ALU_SLT;
					FN_SLTU: aluSel = ALU_SLTU;
					default: aluSel = ALU_ADD;
				endcase
			end
			OP_ADDIU: aluSel = ALU_ADDU;
			OP_SLTI:  aluSel = ALU_SLT;
			OP_ANDI:  aluSel = ALU_AND;
			OP_ORI:   aluSel = ALU_OR;
			OP_XORI:  aluSel = ALU_XOR;
			OP_LUI:   aluSel = ALU_LUI;
			default:  aluSel = ALU_ADD; // Loads, stores, links
		endcase
		aluFn  = (op == OP_SPECIAL) && (fn inside {FN_SLL, FN_SRL, FN_SRA, FN_ADD, FN_ADDU,
			FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU});
		useImm = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
			OP_LW, OP_SW};
		regWr  = aluFn || (useImm && (op != OP_SW)) || (op == OP_JAL);
		jr     = (op == OP_SPECIAL) && (fn == FN_JR);
		isJump = jr || (op == OP_J) || (op == OP_JAL);
		if (op == OP_LUI)
			imm = {instr[15:0], 16'h0000};
		else if (op inside {OP_ANDI, OP_ORI, OP_XORI})
			imm = {16'h0000, instr[15:0]};
		else
			imm = immS;
		case (op)
			OP_BEQ:  cond = (a == b);
			OP_BNE:  cond = (a != b);
			OP_BLEZ: cond = ($signed(a) <= 0);
			OP_BGTZ: cond = ($signed(a) > 0);
			default: cond = 1'b0;
		endcase
		r.stage.writeReg  = (op == OP_SPECIAL) ? instr[15:11] :
			((op == OP_JAL) ? 5'd31 : instr[20:16]);
		r.stage.memRead   = (op == OP_LW);
		r.stage.memToReg  = (op == OP_LW);
		r.stage.memWrite  = (op == OP_SW);
		r.stage.writeBack = (regWr && (r.stage.writeReg != 5'd0)) || r.stage.memToReg;
		r.stage.aOut      = (op == OP_JAL) ? pca : a;
		r.stage.bOut      = (op == OP_JAL) ? 32'd4 : (useImm ? imm : b);
		r.stage.storeData = b;
		r.stage.aluOp     = aluSel;
		r.stage.shamt     = instr[10:6];
		r.taken = cond || isJump;
		if (jr)
			r.nextPc = a;
		else if (isJump)
			r.nextPc = {cia[31:28], instr[25:0], 2'b00};
		else if (cond)
			r.nextPc = pca + (immS << 2);
		else
			r.nextPc = pca;
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Compare process on the falling edge
	task automatic checkValue(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	always @(negedge CLK) begin
		if (!RESET)
			expReg = '0;
		res = refDecode();
		checkValue("takenBranch", 32'(takenBranch), 32'(res.taken));
		checkValue("nextPc", nextPc, res.nextPc);
		checkValue("aOut", aOut, expReg.aOut);
		checkValue("bOut", bOut, expReg.bOut);
		checkValue("storeData", storeData, expReg.storeData);
		checkValue("writeReg", 32'(writeReg), 32'(expReg.writeReg));
		checkValue("writeBack", 32'(writeBack), 32'(expReg.writeBack));
		checkValue("memRead", 32'(memRead), 32'(expReg.memRead));
		checkValue("memWrite", 32'(memWrite), 32'(expReg.memWrite));
		checkValue("memToReg", 32'(memToReg), 32'(expReg.memToReg));
		checkValue("aluOp", 32'(aluOp), 32'(expReg.aluOp));
		checkValue("shamt", 32'(shamt), 32'(expReg.shamt));
		if (RESET && !freeze)
			expReg = res.stage;
		if (wbWriteEn)
			modelRegs[wbWriteReg] = wbData; // DUT writes at the next rising edge
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles", cycleCount);
			$display("Test failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	initial begin
		regAddr_t fwdReg;
		word_t    valA;
		word_t    valB;
		RESET       = 1'b0;
		freeze      = 1'b0;
		instr       = '0;
		pca         = 32'd4;
		cia         = '0;
		exResult    = '0;
		memWriteEn  = 1'b0;
		memWriteReg = '0;
		memData     = '0;
		wbWriteEn   = 1'b0;
		wbWriteReg  = '0;
		wbData      = '0;
		foreach (modelRegs[i])
			modelRegs[i] = '0;
		repeat (4) @(posedge CLK);

		// Preload every register while reset is released on the fifth edge
		for (int r = 0; r < 32; r++) begin
			issue(32'h0, 1'b0, '0, 1'b1, regAddr_t'(r), randWord());
			if (r == 0)
				RESET <= 1'b1;
		end

		for (int i = 0; i < 13; i++)
			issue(rType(randReg(), randReg(), randReg(), randReg(), ALU_FNS[i]));

		for (int i = 0; i < 9; i++) begin
			for (int s = 0; s < 2; s++)
				issue(iType(IMM_OPS[i], randReg(), randReg(), randImm(s[0])));
		end
		issue(iType(OP_ADDI, randReg(), 5'd0, randImm(1'b0)));  // No writeback to r0
		issue(iType(OP_ORI, randReg(), 5'd0, randImm(1'b1)));
		issue(rType(randReg(), randReg(), 5'd0, 5'd0, FN_ADD));
		issue(iType(OP_LW, randReg(), 5'd0, randImm(1'b0)));    // Loads still write back

		// Bit 0 execute, bit 1 memory, bit 2 writeback
		for (int c = 0; c < 8; c++) begin
			fwdReg = randReg();
			if (fwdReg == 5'd0)
				fwdReg = 5'd9;
			if (c[0])
				issue(rType(randReg(), randReg(), fwdReg, 5'd0, FN_ADDU));
			else
				issue(32'h0);
			issue(rType(fwdReg, fwdReg, randReg(), 5'd0, FN_SUBU), c[1], fwdReg, c[2], fwdReg,
				randWord());
		end

		// Equal, unequal, negative, zero, positive
		for (int c = 0; c < 5; c++) begin
			valA = randWord();
			valB = randWord();
			case (c)
				0: valB = valA;
				1: valB = valA ^ 32'h10;
				2: valA[31] = 1'b1;
				3: valA = '0;
				default: begin
					valA[31] = 1'b0;
					valA[0]  = 1'b1;
				end
			endcase
			issue(32'h0, 1'b0, '0, 1'b1, 5'd2, valA);
			issue(32'h0, 1'b0, '0, 1'b1, 5'd3, valB);
			for (int k = 0; k < 4; k++)
				issue(iType(BR_OPS[k], 5'd2, 5'd3, randImm(k[0])));
		end

		issue(jType(OP_J, randWord()));
		issue(jType(OP_JAL, randWord()));
		issue(rType(5'd31, 5'd0, 5'd0, 5'd0, FN_JR)); // Link register from execute
		issue(rType(randReg(), 5'd0, 5'd0, 5'd0, FN_JR));

		// Outputs must hold through the frozen cycles
		issue(rType(randReg(), randReg(), randReg(), randReg(), FN_ADD));
		repeat (4)
			issue(rType(randReg(), randReg(), randReg(), randReg(), FN_XOR), 1'b0, '0, 1'b0,
				'0, '0, 1'b1);
		issue(32'h0);

		issue(iType(OP_LW, randReg(), randReg(), randImm(1'b0)));
		RESET <= 1'b0;
		issue(iType(OP_SW, randReg(), randReg(), randImm(1'b1)));
		issue(jType(OP_JAL, randWord()));
		RESET <= 1'b1;
		issue(32'h0);
		issue(rType(randReg(), randReg(), randReg(), 5'd0, FN_OR));
		repeat (2) @(posedge CLK);

		$display("Test passed");
		$finish;
	end
endmodule

`default_nettype wire

/* src.f */
hdl/decodePkg.sv
hdl/decodeIf.sv
hdl/instrDecoder.sv
hdl/operandFetch.sv
hdl/branchUnit.sv
hdl/idexRegister.sv
hdl/decodeStage.sv
dv/decodeStageTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert --timescale 1ns/1ps
TOP      = decodeStageTb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   list targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
